// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // Bank word and port line
    localparam int WORD_W = 32;
    localparam int BANKS_PER_THREAD = 4;

    typedef logic [WORD_W-1:0] word_t;

    // Word 0 in the low bits
    typedef logic [BANKS_PER_THREAD*WORD_W-1:0] line_t;

    typedef logic [31:0] addr_t;

    typedef logic [1:0] bank_sel_t;

    // Word index starts above the byte offset
    localparam int WORD_LSB = 2;

    // Thread field in the port address
    localparam int THREAD_LSB = 16;

    // Dump sequence to the memory controller
    typedef enum logic [1:0] {
        st_idle,
        st_hold,
        st_settle,
        st_stream
    } dump_state_t;

    // Index width for a count of n, never below one bit
    function automatic int idx_bits(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

`default_nettype wire

// ==== bank_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module bank_ram
    import mem_pkg::*;
#(
    parameter int ROW_WIDTH = 8
) (
    input  wire logic                 clk,
    input  wire logic                 we,
    input  wire logic [ROW_WIDTH-1:0] row,
    input  wire word_t                data,
    output word_t                     q
);

    word_t mem [2**ROW_WIDTH];

    // Read returns the old contents on a same-row write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[row] <= data;
        end
        q <= mem[row];
    end

endmodule

`default_nettype wire

// ==== port_addr_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module port_addr_gen
    import mem_pkg::*;
#(
    parameter int NUM_PORTS  = 4,
    parameter int NUM_THREAD = 8,
    parameter int ROW_WIDTH  = 8
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire logic [NUM_PORTS-1:0]                  wr_en,
    input  wire logic [NUM_PORTS-1:0]                  rd_en,
    input  wire addr_t [NUM_PORTS-1:0]                 addr,
    input  wire line_t [NUM_PORTS-1:0]                 wr_data,
    output logic [NUM_PORTS-1:0]                       port_active,
    output logic [NUM_PORTS-1:0]                       port_we,
    output logic [NUM_PORTS-1:0][idx_bits(NUM_THREAD)-1:0] port_thread,
    output logic [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0][ROW_WIDTH-1:0] port_bank_row,
    output word_t [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0] port_bank_data,
    output bank_sel_t [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0] port_bank_sel
);

    localparam int THREAD_W = idx_bits(NUM_THREAD);
    localparam int IDX_W = ROW_WIDTH + 2;

    logic [NUM_PORTS-1:0][THREAD_W-1:0] thread_d;
    logic [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0][ROW_WIDTH-1:0] row_d;
    word_t [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0] data_d;
    bank_sel_t [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0] sel_d;

    always_comb begin
        logic [IDX_W-1:0] w;
        logic [IDX_W-1:0] idx;
        bank_sel_t k;
        for (int p = 0; p < NUM_PORTS; p++) begin
            w = addr[p][WORD_LSB +: IDX_W];
            thread_d[p] = addr[p][THREAD_LSB +: THREAD_W];
            for (int b = 0; b < BANKS_PER_THREAD; b++) begin
                // Line word that lands in bank b
                k = bank_sel_t'(b) - w[1:0];
                idx = w + IDX_W'(k);
                row_d[p][b] = idx[IDX_W-1:2];
                data_d[p][b] = wr_data[p][WORD_W*k +: WORD_W];
                // Bank holding line word b, used on the way back
                sel_d[p][b] = w[1:0] + bank_sel_t'(b);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            port_active <= '0;
            port_we <= '0;
        end else begin
            port_active <= wr_en | rd_en;
            port_we <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        port_thread <= thread_d;
        port_bank_row <= row_d;
        port_bank_data <= data_d;
        port_bank_sel <= sel_d;
    end

endmodule

`default_nettype wire

// ==== thread_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module thread_router
    import mem_pkg::*;
#(
    parameter int NUM_PORTS  = 4,
    parameter int NUM_THREAD = 8,
    parameter int ROW_WIDTH  = 8
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire logic [NUM_PORTS-1:0]                  port_active,
    input  wire logic [NUM_PORTS-1:0]                  port_we,
    input  wire logic [NUM_PORTS-1:0][idx_bits(NUM_THREAD)-1:0] port_thread,
    input  wire logic [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0][ROW_WIDTH-1:0] port_bank_row,
    input  wire word_t [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0] port_bank_data,
    input  wire logic                                  dump_override,
    output logic [NUM_THREAD-1:0]                      bank_we,
    output logic [NUM_THREAD-1:0][BANKS_PER_THREAD-1:0][ROW_WIDTH-1:0] bank_row,
    output word_t [NUM_THREAD-1:0][BANKS_PER_THREAD-1:0] bank_data
);

    localparam int THREAD_W = idx_bits(NUM_THREAD);

    logic [NUM_THREAD-1:0][NUM_PORTS-1:0] hit;

    for (genvar t = 0; t < NUM_THREAD; t++) begin : g_thread
        logic [BANKS_PER_THREAD-1:0][ROW_WIDTH-1:0] sel_row;
        word_t [BANKS_PER_THREAD-1:0] sel_data;

        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_hit
            assign hit[t][p] = port_active[p] && (port_thread[p] == THREAD_W'(t));
        end

        // At most one port per thread, so the last match is the only one
        always_comb begin
            sel_row = port_bank_row[0];
            sel_data = port_bank_data[0];
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (hit[t][p]) begin
                    sel_row = port_bank_row[p];
                    sel_data = port_bank_data[p];
                end
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                bank_we[t] <= 1'b0;
            end else begin
                bank_we[t] <= |(hit[t] & port_we) && !dump_override;
            end
        end

        // Dump parks every bank on the last row
        always_ff @(posedge clk) begin
            bank_row[t] <= dump_override ? '1 : sel_row;
            bank_data[t] <= sel_data;
        end

        a_one_port_per_thread : assert property (
            @(posedge clk) disable iff (!rst_n) $onehot0(hit[t])
        ) else $error("two ports hit thread %0d in one cycle", t);
    end

endmodule

`default_nettype wire

// ==== read_return.sv ====
`timescale 1ns/10ps
`default_nettype none

module read_return
    import mem_pkg::*;
#(
    parameter int NUM_PORTS  = 4,
    parameter int NUM_THREAD = 8
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire logic [NUM_PORTS-1:0]                  rd_en,
    input  wire logic [NUM_PORTS-1:0][idx_bits(NUM_THREAD)-1:0] port_thread,
    input  wire bank_sel_t [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0] port_bank_sel,
    input  wire word_t [NUM_THREAD-1:0][BANKS_PER_THREAD-1:0] bank_q,
    output logic [NUM_PORTS-1:0]                       rd_valid,
    output line_t [NUM_PORTS-1:0]                      rd_data
);

    localparam int THREAD_W = idx_bits(NUM_THREAD);

    logic [NUM_PORTS-1:0] vld_s0;
    logic [NUM_PORTS-1:0] vld_s1;
    logic [NUM_PORTS-1:0] vld_s2;

    logic [NUM_PORTS-1:0][THREAD_W-1:0] thread_d1;
    logic [NUM_PORTS-1:0][THREAD_W-1:0] thread_d2;

    bank_sel_t [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0] sel_d1;
    bank_sel_t [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0] sel_d2;
    bank_sel_t [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0] sel_d3;

    word_t [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0] pick;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_s0 <= '0;
            vld_s1 <= '0;
            vld_s2 <= '0;
            rd_valid <= '0;
        end else begin
            vld_s0 <= rd_en;
            vld_s1 <= vld_s0;
            vld_s2 <= vld_s1;
            rd_valid <= vld_s2;
        end
    end

    // Thread is needed when bank data arrives, bank order one stage later
    always_ff @(posedge clk) begin
        thread_d1 <= port_thread;
        thread_d2 <= thread_d1;
        sel_d1 <= port_bank_sel;
        sel_d2 <= sel_d1;
        sel_d3 <= sel_d2;
        for (int p = 0; p < NUM_PORTS; p++) begin
            pick[p] <= bank_q[thread_d2[p]];
        end
    end

    // Un-rotate bank words into line order
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int k = 0; k < BANKS_PER_THREAD; k++) begin
                rd_data[p][WORD_W*k +: WORD_W] = pick[p][sel_d3[p][k]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== dump_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module dump_ctrl
    import mem_pkg::*;
#(
    parameter int NUM_THREAD = 8
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire logic                                  dump_start,
    input  wire logic                                  wr_en,
    input  wire logic                                  rd_en,
    input  wire word_t [NUM_THREAD-1:0][BANKS_PER_THREAD-1:0] bank_q,
    output logic                                       dump_override,
    output logic                                       dump_valid,
    output line_t                                      dump_data
);

    localparam int THREAD_W = idx_bits(NUM_THREAD);

    dump_state_t state;
    dump_state_t state_nxt;

    logic [THREAD_W-1:0] thread_cnt;
    logic                last_thread;

    assign last_thread = (thread_cnt == THREAD_W'(NUM_THREAD - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (dump_start) begin
                    state_nxt = st_hold;
                end
            end
            // Router, then banks, pick up the last row
            st_hold:   state_nxt = st_settle;
            st_settle: state_nxt = st_stream;
            st_stream: begin
                if (last_thread) begin
                    state_nxt = st_idle;
                end
            end
            default:   state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            thread_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == st_stream) begin
                thread_cnt <= last_thread ? '0 : thread_cnt + 1'b1;
            end
        end
    end

    assign dump_override = (state != st_idle);
    assign dump_valid = (state == st_stream);

    // Bank 0 lands in the low word
    assign dump_data = bank_q[thread_cnt];

    a_no_access_in_dump : assert property (
        @(posedge clk) disable iff (!rst_n) (state != st_idle) |-> !(wr_en || rd_en)
    ) else $error("port access during controller dump");

endmodule

`default_nettype wire

// ==== main_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module main_mem
    import mem_pkg::*;
#(
    parameter int NUM_PORTS  = 4,
    parameter int NUM_THREAD = 8,
    parameter int ROW_WIDTH  = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [NUM_PORTS-1:0]  wr_en,
    input  wire logic [NUM_PORTS-1:0]  rd_en,
    input  wire addr_t [NUM_PORTS-1:0] addr,
    input  wire line_t [NUM_PORTS-1:0] wr_data,
    output logic [NUM_PORTS-1:0]       rd_valid,
    output line_t [NUM_PORTS-1:0]      rd_data,
    input  wire logic                  dump_start,
    output logic                       dump_valid,
    output line_t                      dump_data
);

    localparam int THREAD_W = idx_bits(NUM_THREAD);

    logic [NUM_PORTS-1:0]                                     port_active;
    logic [NUM_PORTS-1:0]                                     port_we;
    logic [NUM_PORTS-1:0][THREAD_W-1:0]                       port_thread;
    logic [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0][ROW_WIDTH-1:0] port_bank_row;
    word_t [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0]              port_bank_data;
    bank_sel_t [NUM_PORTS-1:0][BANKS_PER_THREAD-1:0]          port_bank_sel;

    logic [NUM_THREAD-1:0]                                     bank_we;
    logic [NUM_THREAD-1:0][BANKS_PER_THREAD-1:0][ROW_WIDTH-1:0] bank_row;
    word_t [NUM_THREAD-1:0][BANKS_PER_THREAD-1:0]              bank_data;
    word_t [NUM_THREAD-1:0][BANKS_PER_THREAD-1:0]              bank_q;

    logic dump_override;

    port_addr_gen #(
        .NUM_PORTS(NUM_PORTS),
        .NUM_THREAD(NUM_THREAD),
        .ROW_WIDTH(ROW_WIDTH)
    ) u_addr_gen (
        .clk(clk),
        .rst_n(rst_n),
        .wr_en(wr_en),
        .rd_en(rd_en),
        .addr(addr),
        .wr_data(wr_data),
        .port_active(port_active),
        .port_we(port_we),
        .port_thread(port_thread),
        .port_bank_row(port_bank_row),
        .port_bank_data(port_bank_data),
        .port_bank_sel(port_bank_sel)
    );

    thread_router #(
        .NUM_PORTS(NUM_PORTS),
        .NUM_THREAD(NUM_THREAD),
        .ROW_WIDTH(ROW_WIDTH)
    ) u_router (
        .clk(clk),
        .rst_n(rst_n),
        .port_active(port_active),
        .port_we(port_we),
        .port_thread(port_thread),
        .port_bank_row(port_bank_row),
        .port_bank_data(port_bank_data),
        .dump_override(dump_override),
        .bank_we(bank_we),
        .bank_row(bank_row),
        .bank_data(bank_data)
    );

    for (genvar t = 0; t < NUM_THREAD; t++) begin : g_thread
        for (genvar b = 0; b < BANKS_PER_THREAD; b++) begin : g_bank
            bank_ram #(
                .ROW_WIDTH(ROW_WIDTH)
            ) u_bank (
                .clk(clk),
                .we(bank_we[t]),
                .row(bank_row[t][b]),
                .data(bank_data[t][b]),
                .q(bank_q[t][b])
            );
        end
    end

    read_return #(
        .NUM_PORTS(NUM_PORTS),
        .NUM_THREAD(NUM_THREAD)
    ) u_read_return (
        .clk(clk),
        .rst_n(rst_n),
        .rd_en(rd_en),
        .port_thread(port_thread),
        .port_bank_sel(port_bank_sel),
        .bank_q(bank_q),
        .rd_valid(rd_valid),
        .rd_data(rd_data)
    );

    // Any-port strobes for the dump access check
    dump_ctrl #(
        .NUM_THREAD(NUM_THREAD)
    ) u_dump_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .dump_start(dump_start),
        .wr_en(|wr_en),
        .rd_en(|rd_en),
        .bank_q(bank_q),
        .dump_override(dump_override),
        .dump_valid(dump_valid),
        .dump_data(dump_data)
    );

endmodule

`default_nettype wire

// ==== tb_main_mem_ref.svh ====
`ifndef TB_MAIN_MEM_REF_SVH
`define TB_MAIN_MEM_REF_SVH

// Word index wraps inside the thread
function automatic void record_write(input int thread, input int start, input line_t data);
    for (int k = 0; k < 4; k++) begin
        shadow[thread][(start + k) % IDX_N] = data[32*k +: 32];
    end
endfunction

// Line word k comes from word index start + k
function automatic line_t expect_line(input int thread, input int start);
    line_t line;
    for (int k = 0; k < 4; k++) begin
        line[32*k +: 32] = shadow[thread][(start + k) % IDX_N];
    end
    return line;
endfunction

// Last row of the four banks, bank 0 in the low word
function automatic line_t expect_dump(input int thread);
    line_t line;
    for (int b = 0; b < 4; b++) begin
        line[32*b +: 32] = shadow[thread][IDX_N - 4 + b];
    end
    return line;
endfunction

`endif

// ==== tb_main_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_main_mem
    import mem_pkg::*;
();

    localparam int NUM_PORTS = 4;
    localparam int NUM_THREAD = 8;
    localparam int ROW_WIDTH = 8;
    localparam int THREAD_W = $clog2(NUM_THREAD);
    localparam int IDX_W = ROW_WIDTH + 2;
    localparam int IDX_N = 1 << IDX_W;
    localparam int T1_OPS = 32;
    localparam int T2_OPS = 48;
    localparam int T3_OPS = 200;
    localparam int T4_OPS = 40;
    localparam int DRAIN_LIMIT = 20;
    // Reset, fill, the six tests and their drains
    localparam int RUN_CYCLES = 3 + (IDX_N / 4) * NUM_THREAD / NUM_PORTS + 2 * T1_OPS
        + T2_OPS + T3_OPS + 6 * T4_OPS + 2 * (3 * NUM_THREAD + 16) + 6 * DRAIN_LIMIT + 100;

    logic clk;
    logic rst_n;
    logic [NUM_PORTS-1:0] wr_en;
    logic [NUM_PORTS-1:0] rd_en;
    addr_t [NUM_PORTS-1:0] addr;
    line_t [NUM_PORTS-1:0] wr_data;
    logic [NUM_PORTS-1:0] rd_valid;
    line_t [NUM_PORTS-1:0] rd_data;
    logic dump_start;
    logic dump_valid;
    line_t dump_data;

    word_t shadow [NUM_THREAD][IDX_N];
    line_t exp_q [NUM_PORTS][$];
    int iss_q [NUM_PORTS][$];
    int t1_start [T1_OPS][NUM_PORTS];
    integer seed = 32'h3865c612;
    int cycle = 0;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int dump_issue = 0;
    int dump_idx = NUM_THREAD;
    string test_name = "reset";

    `include "tb_main_mem_ref.svh"

    main_mem #(
        .NUM_PORTS(NUM_PORTS),
        .NUM_THREAD(NUM_THREAD),
        .ROW_WIDTH(ROW_WIDTH)
    ) UUT (
        .clk(clk),
        .rst_n(rst_n),
        .wr_en(wr_en),
        .rd_en(rd_en),
        .addr(addr),
        .wr_data(wr_data),
        .rd_valid(rd_valid),
        .rd_data(rd_data),
        .dump_start(dump_start),
        .dump_valid(dump_valid),
        .dump_data(dump_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (RUN_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles in test %s", RUN_CYCLES, test_name);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic line_t rand_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // Fill word carries thread and word index
    function automatic line_t fill_line(input int thread, input int start);
        line_t line;
        for (int k = 0; k < 4; k++) begin
            line[32*k +: 32] = {8'h5a, 8'(thread), 16'(start + k)};
        end
        return line;
    endfunction

    function automatic bit reads_pending();
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            n += exp_q[p].size();
        end
        return n != 0;
    endfunction

    // Noise in the byte offset and the unused bits below the thread field
    task automatic drive_port(input int p, input bit we, input int thread, input int start,
                              input line_t data);
        addr_t a;
        a = addr_t'($random(seed)) & 32'h0000_f003;
        a[THREAD_LSB +: THREAD_W] = THREAD_W'(thread);
        a[2 +: IDX_W] = IDX_W'(start);
        addr[p] = a;
        wr_data[p] = data;
        if (we) begin
            wr_en[p] = 1'b1;
            record_write(thread, start, data);
        end else begin
            rd_en[p] = 1'b1;
            exp_q[p].push_back(expect_line(thread, start));
            iss_q[p].push_back(cycle + 1);
        end
    endtask

    task automatic tick();
        @(negedge clk);
        wr_en = '0;
        rd_en = '0;
        dump_start = 1'b0;
    endtask

    task automatic start_dump();
        dump_start = 1'b1;
        dump_issue = cycle + 1;
        dump_idx = 0;
        tick();
    endtask

    task automatic wait_reads_done();
        int n;
        n = 0;
        while (reads_pending() && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (reads_pending()) begin
            $display("Read responses missing at the end of test %s", test_name);
            errors++;
            for (int p = 0; p < NUM_PORTS; p++) begin
                exp_q[p].delete();
                iss_q[p].delete();
            end
        end
    endtask

    task automatic wait_dump_done();
        int n;
        n = 0;
        while (dump_idx < NUM_THREAD && n < 3 * NUM_THREAD) begin
            @(negedge clk);
            n++;
        end
        if (dump_idx < NUM_THREAD) begin
            $display("Dump gave only %0d lines in test %s", dump_idx, test_name);
            errors++;
            dump_idx = NUM_THREAD;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
        end
        $display("test %s done with %0d errors", test_name, errors - test_errors);
    endtask

    // Pairs each strobe with the oldest expected line of its port
    always @(posedge clk) begin
        line_t exp_line;
        int iss;
        cycle++;
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (rd_valid[p] && exp_q[p].size() == 0) begin
                    $display("Unexpected rd_valid on port %0d in test %s", p, test_name);
                    errors++;
                end else if (rd_valid[p]) begin
                    exp_line = exp_q[p].pop_front();
                    iss = iss_q[p].pop_front();
                    check_value({test_name, " read data"}, exp_line, rd_data[p]);
                    check_value({test_name, " read latency"}, 128'(4), 128'(cycle - iss));
                end
            end
            if (dump_valid && dump_idx >= NUM_THREAD) begin
                $display("Extra dump_valid cycle in test %s", test_name);
                errors++;
            end else if (dump_valid) begin
                check_value({test_name, " dump data"}, expect_dump(dump_idx), dump_data);
                check_value({test_name, " dump timing"}, 128'(dump_issue + 3 + dump_idx),
                            128'(cycle));
                dump_idx++;
            end
        end
    end

    initial begin
        int base;
        int step;
        rst_n = 1'b0;
        wr_en = '0;
        rd_en = '0;
        addr = '0;
        wr_data = '0;
        dump_start = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        begin_test("reset_aligned");
        check_value("reset rd_valid", '0, 128'(rd_valid));
        check_value("reset dump_valid", '0, 128'(dump_valid));
        for (int r = 0; r < NUM_THREAD / NUM_PORTS; r++) begin
            for (int row = 0; row < IDX_N / 4; row++) begin
                for (int p = 0; p < NUM_PORTS; p++) begin
                    drive_port(p, 1'b1, r * NUM_PORTS + p, 4 * row,
                               fill_line(r * NUM_PORTS + p, 4 * row));
                end
                tick();
            end
        end
        for (int i = 0; i < T1_OPS; i++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                t1_start[i][p] = 4 * rand_below(IDX_N / 4);
                drive_port(p, 1'b1, (2 * p + i) % NUM_THREAD, t1_start[i][p], rand_line());
            end
            tick();
        end
        for (int i = 0; i < T1_OPS; i++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                drive_port(p, 1'b0, (2 * p + i) % NUM_THREAD, t1_start[i][p], '0);
            end
            tick();
        end
        wait_reads_done();
        end_test();

        // First cycles hit the last word indices of a thread
        begin_test("unaligned_wrap");
        for (int i = 0; i < T2_OPS; i++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                drive_port(p, rand_below(2) == 1, (2 * p + i) % NUM_THREAD,
                           (i < 4) ? IDX_N - 1 - ((i + p) % 4) : rand_below(IDX_N),
                           rand_line());
            end
            tick();
        end
        wait_reads_done();
        end_test();

        // Odd step keeps the four threads of a cycle distinct
        begin_test("multi_port");
        for (int i = 0; i < T3_OPS; i++) begin
            base = rand_below(NUM_THREAD);
            step = 2 * rand_below(NUM_THREAD / 2) + 1;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (rand_below(4) != 0) begin
                    drive_port(p, rand_below(2) == 1, (base + p * step) % NUM_THREAD,
                               rand_below(IDX_N), rand_line());
                end
            end
            tick();
        end
        wait_reads_done();
        end_test();

        begin_test("read_latency");
        for (int i = 0; i < T4_OPS; i++) begin
            drive_port(i % NUM_PORTS, rand_below(2) == 1, rand_below(NUM_THREAD),
                       rand_below(IDX_N), rand_line());
            tick();
            repeat (rand_below(5)) tick();
        end
        wait_reads_done();
        end_test();

        begin_test("dump");
        for (int r = 1; r >= 0; r--) begin
            for (int g = 0; g < NUM_THREAD / NUM_PORTS; g++) begin
                for (int p = 0; p < NUM_PORTS; p++) begin
                    drive_port(p, r == 1, g * NUM_PORTS + p, IDX_N - 4, rand_line());
                end
                tick();
            end
        end
        wait_reads_done();
        start_dump();
        wait_dump_done();
        repeat (3) tick();
        end_test();

        // Start pulses land in hold and stream only
        begin_test("dump_restart");
        start_dump();
        for (int j = 0; j < NUM_THREAD; j++) begin
            dump_start = (j % 2 == 0);
            tick();
        end
        wait_dump_done();
        repeat (3) tick();
        for (int i = 0; i < 4; i++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                drive_port(p, 1'b0, (2 * p + i) % NUM_THREAD, rand_below(IDX_N), '0);
            end
            tick();
        end
        wait_reads_done();
        end_test();

        $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== main_mem.f ====
+incdir+.
mem_pkg.sv
bank_ram.sv
port_addr_gen.sv
thread_router.sv
read_return.sv
dump_ctrl.sv
main_mem.sv
tb_main_mem.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' main_mem.f)

.PHONY: run clean

run: obj_dir/Vtb_main_mem
	@out=$$(./obj_dir/Vtb_main_mem); echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

obj_dir/Vtb_main_mem: main_mem.f $(SRCS) tb_main_mem_ref.svh
	verilator --binary --timing --assert -Wno-fatal --top-module tb_main_mem -f main_mem.f

clean:
	rm -rf obj_dir
